/* design/axi_store_consts.svh */
`ifndef AXI_STORE_CONSTS_SVH
`define AXI_STORE_CONSTS_SVH

// ========================================
// bus and user widths
// ========================================
`define AXS_USER_DW      64
`define AXS_BUS_DW       32
`define AXS_ADDR_W       32
`define AXS_LEN_W        32

// byte-address shifts for one user word and one bus beat
`define AXS_USER_ALIGN   3
`define AXS_BUS_ALIGN    2
`define AXS_SPLIT        2

// base of the target region
`define AXS_TARGET_ADDR  32'h1000_0000

// ========================================
// queue depths
// ========================================
`define AXS_REQ_DEPTH    16
`define AXS_OUTSTANDING  2
`define AXS_WBUFF_DEPTH  8

`endif

/* design/axi_store_pkg.sv */
`include "axi_store_consts.svh"

package axi_store_pkg;

    // addresses and lengths
    typedef logic [`AXS_ADDR_W-1:0] addr_t;
    typedef logic [`AXS_LEN_W-1:0] len_t;

    // user side word
    typedef logic [`AXS_USER_DW-1:0] user_data_t;
    typedef logic [`AXS_USER_DW/8-1:0] user_strb_t;

    // bus side beat
    typedef logic [`AXS_BUS_DW-1:0] bus_data_t;
    typedef logic [`AXS_BUS_DW/8-1:0] bus_strb_t;

    // beats minus one, byte length without the bus byte bits
    typedef logic [`AXS_LEN_W-`AXS_BUS_ALIGN-1:0] beat_cnt_t;

    // one extra bit so the counter can hold a full queue
    typedef logic [$clog2(`AXS_REQ_DEPTH):0] rsp_cnt_t;

endpackage

/* design/sync_fifo.sv */
module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             ACLK,
    input  logic             ARESET,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full_n,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty_n
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign full_n  = (count != CNT_W'(DEPTH));
    assign empty_n = (count != '0);
    assign push    = wr_en && full_n;
    assign pop     = rd_en && empty_n;

    // head entry falls through
    assign dout = mem[rd_ptr];

    always_ff @(posedge ACLK) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* design/write_request_stage.sv */
`include "axi_store_consts.svh"

module write_request_stage (
    input  logic                      ACLK,
    input  logic                      ARESET,
    // user request
    input  axi_store_pkg::addr_t      req_addr,
    input  axi_store_pkg::len_t       req_len,
    input  logic                      req_valid,
    output logic                      req_ready,
    // bus address
    output axi_store_pkg::addr_t      aw_addr,
    output axi_store_pkg::len_t       aw_len,
    output logic                      aw_valid,
    input  logic                      aw_ready,
    // response kind to the tracker
    input  logic                      kind_ready,
    output logic                      kind_push,
    output logic                      kind_valid_len,
    // beat count to the splitter
    output logic                      beat_push,
    output axi_store_pkg::beat_cnt_t  beat_cnt,
    input  logic                      beat_space
);

    axi_store_pkg::addr_t q_addr;
    axi_store_pkg::len_t  q_len;
    logic                 q_valid;
    logic                 next_req;
    logic                 valid_len;
    logic                 aw_leave;
    logic                 addr_valid;
    axi_store_pkg::len_t  beat_sum;

    sync_fifo #(
        .WIDTH   ($bits(axi_store_pkg::addr_t) + $bits(axi_store_pkg::len_t)),
        .DEPTH   (`AXS_REQ_DEPTH)
    ) req_queue (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr_en   (req_valid),
        .din     ({req_len, req_addr}),
        .full_n  (req_ready),
        .rd_en   (next_req),
        .dout    ({q_len, q_addr}),
        .empty_n (q_valid)
    );

    // zero or top bit set is rejected
    assign valid_len = (q_len != '0) && !q_len[`AXS_LEN_W-1];

    assign aw_leave  = aw_valid && aw_ready;
    assign next_req  = q_valid && (!addr_valid || aw_leave) && kind_ready;

    assign kind_push      = next_req;
    assign kind_valid_len = valid_len;

    // hold off the address until the splitter can take its beat count
    assign aw_valid  = addr_valid && beat_space;
    assign beat_push = aw_leave;
    assign beat_sum  = aw_len + axi_store_pkg::len_t'(aw_addr[`AXS_BUS_ALIGN-1:0]);
    assign beat_cnt  = beat_sum[`AXS_LEN_W-1:`AXS_BUS_ALIGN];

    // ========================================
    // address register
    // ========================================
    always_ff @(posedge ACLK) begin
        if (next_req) begin
            aw_addr <= `AXS_TARGET_ADDR + (q_addr << `AXS_USER_ALIGN);
            aw_len  <= (q_len << `AXS_USER_ALIGN) - 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            addr_valid <= 1'b0;
        end else if (next_req && valid_len) begin
            addr_valid <= 1'b1;
        end else if (aw_leave) begin
            addr_valid <= 1'b0;
        end
    end

endmodule

/* design/write_data_splitter.sv */
`include "axi_store_consts.svh"

module write_data_splitter (
    input  logic                      ACLK,
    input  logic                      ARESET,
    // user data
    input  axi_store_pkg::user_data_t wr_data,
    input  axi_store_pkg::user_strb_t wr_strb,
    input  logic                      wr_valid,
    output logic                      wr_ready,
    // beat counts from the request stage
    input  logic                      beat_push,
    input  axi_store_pkg::beat_cnt_t  beat_cnt,
    output logic                      beat_space,
    // bus data
    output axi_store_pkg::bus_data_t  w_data,
    output axi_store_pkg::bus_strb_t  w_strb,
    output logic                      w_valid,
    input  logic                      w_ready
);

    axi_store_pkg::user_data_t        wbuf_data;
    axi_store_pkg::user_strb_t        wbuf_strb;
    logic                             wbuf_valid;
    axi_store_pkg::beat_cnt_t         beat_len;
    logic                             entry_valid;
    logic                             next_entry;
    axi_store_pkg::beat_cnt_t         beat_idx;
    logic [$clog2(`AXS_SPLIT)-1:0]    split_cnt;
    logic                             ready_for_data;
    logic                             first_split;
    logic                             next_split;
    logic                             last_split;
    axi_store_pkg::user_data_t        data_sr;
    axi_store_pkg::user_strb_t        strb_sr;

    sync_fifo #(
        .WIDTH   ($bits(axi_store_pkg::user_data_t) + $bits(axi_store_pkg::user_strb_t)),
        .DEPTH   (`AXS_WBUFF_DEPTH)
    ) data_buffer (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr_en   (wr_valid),
        .din     ({wr_strb, wr_data}),
        .full_n  (wr_ready),
        .rd_en   (first_split),
        .dout    ({wbuf_strb, wbuf_data}),
        .empty_n (wbuf_valid)
    );

    sync_fifo #(
        .WIDTH   ($bits(axi_store_pkg::beat_cnt_t)),
        .DEPTH   (`AXS_OUTSTANDING)
    ) beat_queue (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr_en   (beat_push),
        .din     (beat_cnt),
        .full_n  (beat_space),
        .rd_en   (next_entry),
        .dout    (beat_len),
        .empty_n (entry_valid)
    );

    assign ready_for_data = !w_valid || w_ready;
    // a new word needs both the data and its request's beat count
    assign first_split = (split_cnt == '0) && wbuf_valid && entry_valid && ready_for_data;
    assign next_split  = (split_cnt != '0) && ready_for_data;
    assign last_split  = (32'(split_cnt) == `AXS_SPLIT - 1) && ready_for_data;
    assign next_entry  = (beat_idx == beat_len) && entry_valid && last_split;

    // low half goes out first
    assign w_data = data_sr[`AXS_BUS_DW-1:0];
    assign w_strb = strb_sr[`AXS_BUS_DW/8-1:0];

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            split_cnt <= '0;
            beat_idx  <= '0;
            w_valid   <= 1'b0;
        end else begin
            if (last_split) begin
                split_cnt <= '0;
            end else if (first_split || next_split) begin
                split_cnt <= split_cnt + 1'b1;
            end
            if (next_entry) begin
                beat_idx <= '0;
            end else if (first_split || next_split) begin
                beat_idx <= beat_idx + 1'b1;
            end
            if (first_split || next_split) begin
                w_valid <= 1'b1;
            end else if (ready_for_data) begin
                w_valid <= 1'b0;
            end
        end
    end

    // ========================================
    // beat shift register
    // ========================================
    always_ff @(posedge ACLK) begin
        if (first_split) begin
            data_sr <= wbuf_data;
            strb_sr <= wbuf_strb;
        end else if (next_split) begin
            data_sr <= data_sr >> `AXS_BUS_DW;
            strb_sr <= strb_sr >> (`AXS_BUS_DW / 8);
        end
    end

endmodule

/* design/write_response_tracker.sv */
`include "axi_store_consts.svh"

module write_response_tracker (
    input  logic ACLK,
    input  logic ARESET,
    // response kinds from the request stage
    input  logic kind_push,
    input  logic kind_valid_len,
    output logic kind_ready,
    // bus response
    input  logic b_valid,
    output logic b_ready,
    // user response
    output logic rsp_valid,
    input  logic rsp_ready
);

    logic                    head_valid_len;
    logic                    kind_avail;
    logic                    kind_retire;
    logic                    cnt_room;
    logic                    rsp_xfer;
    axi_store_pkg::rsp_cnt_t rsp_cnt;

    // one bit per request, set for a valid length
    sync_fifo #(
        .WIDTH   (1),
        .DEPTH   (`AXS_OUTSTANDING)
    ) kind_queue (
        .ACLK    (ACLK),
        .ARESET  (ARESET),
        .wr_en   (kind_push),
        .din     (kind_valid_len),
        .full_n  (kind_ready),
        .rd_en   (kind_retire),
        .dout    (head_valid_len),
        .empty_n (kind_avail)
    );

    assign cnt_room    = (rsp_cnt != axi_store_pkg::rsp_cnt_t'(`AXS_REQ_DEPTH));
    // invalid requests retire without waiting on the bus
    assign kind_retire = kind_avail && (!head_valid_len || b_valid) && cnt_room;
    assign b_ready     = kind_avail && head_valid_len && cnt_room;
    assign rsp_xfer    = rsp_valid && rsp_ready;
    assign rsp_valid   = (rsp_cnt != '0);

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            rsp_cnt <= '0;
        end else if (kind_retire && !rsp_xfer) begin
            rsp_cnt <= rsp_cnt + 1'b1;
        end else if (rsp_xfer && !kind_retire) begin
            rsp_cnt <= rsp_cnt - 1'b1;
        end
    end

endmodule

/* design/axi_store_top.sv */
module axi_store_top (
    input  logic                      ACLK,
    input  logic                      ARESET,
    // user side
    input  axi_store_pkg::addr_t      req_addr,
    input  axi_store_pkg::len_t       req_len,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  axi_store_pkg::user_data_t wr_data,
    input  axi_store_pkg::user_strb_t wr_strb,
    input  logic                      wr_valid,
    output logic                      wr_ready,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    // bus side
    output axi_store_pkg::addr_t      aw_addr,
    output axi_store_pkg::len_t       aw_len,
    output logic                      aw_valid,
    input  logic                      aw_ready,
    output axi_store_pkg::bus_data_t  w_data,
    output axi_store_pkg::bus_strb_t  w_strb,
    output logic                      w_valid,
    input  logic                      w_ready,
    input  logic                      b_valid,
    output logic                      b_ready
);

    logic                     kind_ready;
    logic                     kind_push;
    logic                     kind_valid_len;
    logic                     beat_push;
    axi_store_pkg::beat_cnt_t beat_cnt;
    logic                     beat_space;

    write_request_stage request_stage (
        .ACLK(ACLK), .ARESET(ARESET),
        .req_addr(req_addr), .req_len(req_len), .req_valid(req_valid), .req_ready(req_ready),
        .aw_addr(aw_addr), .aw_len(aw_len), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .kind_ready(kind_ready), .kind_push(kind_push), .kind_valid_len(kind_valid_len),
        .beat_push(beat_push), .beat_cnt(beat_cnt), .beat_space(beat_space)
    );

    write_data_splitter data_splitter (
        .ACLK(ACLK), .ARESET(ARESET),
        .wr_data(wr_data), .wr_strb(wr_strb), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .beat_push(beat_push), .beat_cnt(beat_cnt), .beat_space(beat_space),
        .w_data(w_data), .w_strb(w_strb), .w_valid(w_valid), .w_ready(w_ready)
    );

    write_response_tracker response_tracker (
        .ACLK(ACLK), .ARESET(ARESET),
        .kind_push(kind_push), .kind_valid_len(kind_valid_len), .kind_ready(kind_ready),
        .b_valid(b_valid), .b_ready(b_ready),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
    );

endmodule

/* test/axi_store_tb.sv */
module axi_store_tb;

    localparam int NUM_ROWS = 8;
    localparam int TIMEOUT_CYCLES = 2000;

    // one table row with the request, its data seed, stall enable and expected burst
    typedef struct packed {
        axi_store_pkg::addr_t waddr;
        axi_store_pkg::len_t  len;
        logic [31:0]          seed;
        logic                 stall;
        logic                 burst;
    } row_t;

    logic ACLK = 1'b0;
    logic ARESET = 1'b1;
    logic req_valid, req_ready, wr_valid, wr_ready, rsp_valid, rsp_ready;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    axi_store_pkg::addr_t      req_addr, aw_addr;
    axi_store_pkg::len_t       req_len, aw_len;
    axi_store_pkg::user_data_t wr_data;
    axi_store_pkg::user_strb_t wr_strb;
    axi_store_pkg::bus_data_t  w_data;
    axi_store_pkg::bus_strb_t  w_strb;

    row_t                      rows [NUM_ROWS];
    // expected bus traffic, in order
    axi_store_pkg::addr_t      exp_addr [$];
    axi_store_pkg::len_t       exp_len [$];
    logic                      exp_aw_stall [$];
    axi_store_pkg::bus_data_t  exp_data [$];
    axi_store_pkg::bus_strb_t  exp_strb [$];
    logic                      exp_beat_stall [$];
    axi_store_pkg::user_data_t word_data [$];
    axi_store_pkg::user_strb_t word_strb [$];
    int                        open_beats [$];
    int                        req_i, word_i, aw_i, beat_i, rsp_i, pending_b, b_done;
    logic [31:0]               stall_rnd = 32'hb7da7210;

    always #20 ACLK = ~ACLK;

    axi_store_top dut_i (.*);

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // ready drops about one cycle in four on stall rows
    function automatic logic stall_ready(logic stall);
        stall_rnd = xorshift(stall_rnd);
        return !stall || (stall_rnd[1:0] != 2'b00);
    endfunction

    // ========================================
    // checks
    // ========================================
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
        abort_run($sformatf("Fail %s expected %0h actual %0h", name, exp, act));
    endtask

    task automatic check_addr(string name, axi_store_pkg::addr_t exp, axi_store_pkg::addr_t act);
        if (exp !== act)
            report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_len(string name, axi_store_pkg::len_t exp, axi_store_pkg::len_t act);
        if (exp !== act)
            report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_data(string name, axi_store_pkg::bus_data_t exp,
                              axi_store_pkg::bus_data_t act);
        if (exp !== act)
            report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_strb(string name, axi_store_pkg::bus_strb_t exp,
                              axi_store_pkg::bus_strb_t act);
        if (exp !== act)
            report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_count(string name, axi_store_pkg::rsp_cnt_t exp,
                               axi_store_pkg::rsp_cnt_t act);
        if (exp !== act)
            report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_quiet(string when);
        if (aw_valid !== 1'b0 || w_valid !== 1'b0 || rsp_valid !== 1'b0 || b_ready !== 1'b0)
            abort_run($sformatf("a valid or b_ready was not low %s", when));
    endtask

    // user driver, bus slave model and response sink for one clock
    task automatic service_cycle();
        int need;
        @(negedge ACLK);
        req_valid = (req_i < NUM_ROWS);
        if (req_valid) begin
            req_addr = rows[req_i].waddr;
            req_len  = rows[req_i].len;
        end
        wr_valid = (word_i < word_data.size());
        if (wr_valid) begin
            wr_data = word_data[word_i];
            wr_strb = word_strb[word_i];
        end
        aw_ready  = stall_ready(aw_i < exp_aw_stall.size() && exp_aw_stall[aw_i]);
        w_ready   = stall_ready(beat_i < exp_beat_stall.size() && exp_beat_stall[beat_i]);
        rsp_ready = stall_ready(rsp_i < NUM_ROWS && rows[rsp_i].stall);
        b_valid   = (pending_b > 0);
        // outputs are registered, so these are the values at the next rising edge
        if (req_valid && req_ready)
            req_i++;
        if (wr_valid && wr_ready)
            word_i++;
        if (aw_valid && aw_ready) begin
            if (aw_i >= exp_addr.size())
                abort_run("address transfer with no valid request left");
            check_addr($sformatf("aw %0d addr", aw_i), exp_addr[aw_i], aw_addr);
            check_len($sformatf("aw %0d len", aw_i), exp_len[aw_i], aw_len);
            open_beats.push_back((int'(exp_len[aw_i]) + 1) / 4);
            aw_i++;
        end
        if (w_valid && w_ready) begin
            if (open_beats.size() == 0 || beat_i >= exp_data.size())
                abort_run("write beat with no open burst");
            check_data($sformatf("beat %0d data", beat_i), exp_data[beat_i], w_data);
            check_strb($sformatf("beat %0d strb", beat_i), exp_strb[beat_i], w_strb);
            beat_i++;
            open_beats[0] = open_beats[0] - 1;
            if (open_beats[0] == 0) begin
                void'(open_beats.pop_front());
                pending_b++;
            end
        end
        if (rsp_valid && rsp_ready) begin
            if (rsp_i < NUM_ROWS) begin
                need = 0;
                for (int k = 0; k <= rsp_i; k++)
                    need += int'(rows[k].burst);
                if (b_done < need)
                    abort_run($sformatf("response %0d came before its bus response", rsp_i));
            end
            rsp_i++;
        end
        if (b_valid && b_ready) begin
            pending_b--;
            b_done++;
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        int cycles;
        axi_store_pkg::user_data_t word;
        logic [31:0] rnd;
        // word address, length, data seed, stall enable, burst expected
        rows[0] = '{32'h0000_0000, 32'd1, 32'h1f2e_3d4c, 1'b0, 1'b1};
        rows[1] = '{32'h0000_0010, 32'd3, 32'h5a5a_0001, 1'b0, 1'b1};
        rows[2] = '{32'h0000_0005, 32'd0, 32'h0000_0000, 1'b0, 1'b0};
        rows[3] = '{32'h0000_0123, 32'd2, 32'h7c31_9e02, 1'b1, 1'b1};
        rows[4] = '{32'h0000_0007, 32'h8000_0002, 32'h0000_0000, 1'b1, 1'b0};
        rows[5] = '{32'h0000_0040, 32'd4, 32'h93a1_4e17, 1'b1, 1'b1};
        rows[6] = '{32'h0000_0003, 32'hffff_ffff, 32'h0000_0000, 1'b1, 1'b0};
        rows[7] = '{32'h0000_0200, 32'd1, 32'h2b6d_58c3, 1'b0, 1'b1};
        foreach (rows[r]) begin
            if (rows[r].burst) begin
                exp_addr.push_back(32'h1000_0000 + 8 * rows[r].waddr);
                exp_len.push_back(8 * rows[r].len - 1);
                exp_aw_stall.push_back(rows[r].stall);
                rnd = rows[r].seed;
                for (int w = 0; w < int'(rows[r].len); w++) begin
                    rnd = xorshift(rnd);
                    word[31:0] = rnd;
                    rnd = xorshift(rnd);
                    word[63:32] = rnd;
                    rnd = xorshift(rnd);
                    word_data.push_back(word);
                    word_strb.push_back(rnd[7:0]);
                    // low half leaves first
                    exp_data.push_back(word[31:0]);
                    exp_strb.push_back(rnd[3:0]);
                    exp_data.push_back(word[63:32]);
                    exp_strb.push_back(rnd[7:4]);
                    exp_beat_stall.push_back(rows[r].stall);
                    exp_beat_stall.push_back(rows[r].stall);
                end
            end
        end
        req_valid = 1'b0;
        req_addr  = '0;
        req_len   = '0;
        wr_valid  = 1'b0;
        wr_data   = '0;
        wr_strb   = '0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        b_valid   = 1'b0;
        rsp_ready = 1'b0;
        repeat (3) begin
            @(negedge ACLK);
            check_quiet("during reset");
        end
        ARESET = 1'b0;
        @(negedge ACLK);
        check_quiet("on the first cycle after reset");
        cycles = 0;
        while (!(rsp_i >= NUM_ROWS && beat_i == exp_data.size() && aw_i == exp_addr.size()
                 && pending_b == 0)) begin
            if (cycles == TIMEOUT_CYCLES)
                abort_run("timeout waiting for all bursts and responses");
            service_cycle();
            cycles++;
        end
        // idle tail catches stray beats or responses
        repeat (20)
            service_cycle();
        check_count("responses", axi_store_pkg::rsp_cnt_t'(NUM_ROWS),
                    axi_store_pkg::rsp_cnt_t'(rsp_i));
        $display("Simulation passed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/axi_store_pkg.sv
design/sync_fifo.sv
design/write_request_stage.sv
design/write_data_splitter.sv
design/write_response_tracker.sv
design/axi_store_top.sv
test/axi_store_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= axi_store_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
